//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// pc value carried by a reset bubble
`define RESET_PC 32'h0000_0000

`endif

//--- src/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // RV32I major opcodes handled by this pipeline
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // operand source for ALU inputs A and B
    typedef enum logic [1:0] {
        SEL_ZERO,
        SEL_REG,
        SEL_IMM,
        SEL_PC
    } alu_sel_t;

    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    typedef struct packed {
        alu_sel_t   alu_src1;
        alu_sel_t   alu_src2;
        alu_op_t    alu_op;
        logic       mem_write;
        logic       mem_read;
        logic       reg_write;
        logic       mem_to_reg;
        logic [2:0] funct3;
    } ctrl_t;

    // decode bundle held in the ID/EX register
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        ctrl_t            ctrl;
        logic [`XLEN-1:0] read1;
        logic [`XLEN-1:0] read2;
        logic [`XLEN-1:0] imm;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
    } id_ex_t;

    // handed on to the memory stage
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] store_data;
        reg_idx_t         rd;
        logic             reg_write;
        logic             mem_to_reg;
        logic             mem_read;
        logic             mem_write;
        logic [2:0]       funct3;
    } ex_mem_t;

    // controls of a bubble, add zero to zero with nothing enabled
    localparam ctrl_t CTRL_BUBBLE = '{
        alu_src1:   SEL_ZERO,
        alu_src2:   SEL_ZERO,
        alu_op:     ALU_ADD,
        mem_write:  1'b0,
        mem_read:   1'b0,
        reg_write:  1'b0,
        mem_to_reg: 1'b0,
        funct3:     3'b000
    };

endpackage

//--- src/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module instr_decoder (
    input  logic [`XLEN-1:0] instr,
    output rv_pkg::ctrl_t    ctrl,
    output logic [`XLEN-1:0] imm,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    // funct7 bit 5
    logic            alt;

    // sub_sra selects SUB over ADD and SRA over SRL
    function automatic rv_pkg::alu_op_t alu_from_funct(input logic [2:0] f3,
                                                       input logic       sub_sra);
        rv_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = sub_sra ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = sub_sra ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        ctrl = rv_pkg::CTRL_BUBBLE;
        imm  = '0;
        case (opcode)
            rv_pkg::OP: begin
                ctrl.alu_src1  = rv_pkg::SEL_REG;
                ctrl.alu_src2  = rv_pkg::SEL_REG;
                ctrl.alu_op    = alu_from_funct(funct3, alt);
                ctrl.reg_write = 1'b1;
                ctrl.funct3    = funct3;
            end
            rv_pkg::OP_IMM: begin
                ctrl.alu_src1  = rv_pkg::SEL_REG;
                ctrl.alu_src2  = rv_pkg::SEL_IMM;
                // bit 30 is immediate data except for srai
                ctrl.alu_op    = alu_from_funct(funct3, alt && (funct3 == 3'b101));
                ctrl.reg_write = 1'b1;
                ctrl.funct3    = funct3;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            rv_pkg::LUI: begin
                ctrl.alu_src1  = rv_pkg::SEL_ZERO;
                ctrl.alu_src2  = rv_pkg::SEL_IMM;
                ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                ctrl.reg_write = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            rv_pkg::AUIPC: begin
                ctrl.alu_src1  = rv_pkg::SEL_PC;
                ctrl.alu_src2  = rv_pkg::SEL_IMM;
                ctrl.alu_op    = rv_pkg::ALU_ADD;
                ctrl.reg_write = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            rv_pkg::LOAD: begin
                ctrl.alu_src1   = rv_pkg::SEL_REG;
                ctrl.alu_src2   = rv_pkg::SEL_IMM;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.funct3     = funct3;
                imm             = {{20{instr[31]}}, instr[31:20]};
            end
            rv_pkg::STORE: begin
                ctrl.alu_src1  = rv_pkg::SEL_REG;
                ctrl.alu_src2  = rv_pkg::SEL_IMM;
                ctrl.mem_write = 1'b1;
                ctrl.funct3    = funct3;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // unsupported opcodes become a bubble
            default: ;
        endcase
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rstN,
    input  rv_pkg::reg_idx_t     rs1,
    input  rv_pkg::reg_idx_t     rs2,
    output logic [`XLEN-1:0]     read1,
    output logic [`XLEN-1:0]     read2,
    input  logic                 we,
    input  rv_pkg::reg_idx_t     wd_idx,
    input  logic [`XLEN-1:0]     wd
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    // a same-cycle write is passed straight through to the read
    function automatic logic [`XLEN-1:0] read_port(input rv_pkg::reg_idx_t idx);
        logic [`XLEN-1:0] val;
        if (idx == '0)
            val = '0;
        else if (we && (wd_idx == idx))
            val = wd;
        else
            val = regs[idx];
        return val;
    endfunction

    always_comb begin
        read1 = read_port(rs1);
        read2 = read_port(rs2);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && (wd_idx != '0)) begin
            regs[wd_idx] <= wd;
        end
    end

endmodule

//--- src/id_ex_reg.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module id_ex_reg (
    input  logic           clk,
    input  logic           rstN,
    input  rv_pkg::id_ex_t id_in,
    output rv_pkg::id_ex_t id_out
);

    // reset content, an add-zero bubble with all enables low
    localparam rv_pkg::id_ex_t ID_EX_BUBBLE = '{
        pc:    `RESET_PC,
        ctrl:  rv_pkg::CTRL_BUBBLE,
        read1: '0,
        read2: '0,
        imm:   '0,
        rd:    '0,
        rs1:   '0,
        rs2:   '0
    };

    // whole decode bundle moves every edge, no stall or flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            id_out <= ID_EX_BUBBLE;
        else
            id_out <= id_in;
    end

endmodule

//--- src/exec_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module exec_stage (
    input  logic            clk,
    input  logic            rstN,
    input  rv_pkg::id_ex_t  id_ex,
    output rv_pkg::ex_mem_t ex_mem
);

    logic             fwd_valid;
    logic [`XLEN-1:0] src1_val;
    logic [`XLEN-1:0] src2_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;

    function automatic logic [`XLEN-1:0] pick_operand(input rv_pkg::alu_sel_t  sel,
                                                      input logic [`XLEN-1:0] reg_val,
                                                      input logic [`XLEN-1:0] imm,
                                                      input logic [`XLEN-1:0] pc);
        logic [`XLEN-1:0] val;
        case (sel)
            rv_pkg::SEL_REG: val = reg_val;
            rv_pkg::SEL_IMM: val = imm;
            rv_pkg::SEL_PC:  val = pc;
            default:         val = '0;
        endcase
        return val;
    endfunction

    // only ALU results are forwarded, a load holds just its address
    assign fwd_valid = ex_mem.reg_write && !ex_mem.mem_to_reg && (ex_mem.rd != '0);

    assign src1_val = (fwd_valid && (ex_mem.rd == id_ex.rs1)) ? ex_mem.result : id_ex.read1;
    assign src2_val = (fwd_valid && (ex_mem.rd == id_ex.rs2)) ? ex_mem.result : id_ex.read2;

    assign op_a = pick_operand(id_ex.ctrl.alu_src1, src1_val, id_ex.imm, id_ex.pc);
    assign op_b = pick_operand(id_ex.ctrl.alu_src2, src2_val, id_ex.imm, id_ex.pc);

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_result = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_result = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            rv_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_result = op_b;
            default:            alu_result = op_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ex_mem <= '0;
        end else begin
            ex_mem.result     <= alu_result;
            // store data must see the forwarded rs2
            ex_mem.store_data <= src2_val;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.funct3     <= id_ex.ctrl.funct3;
        end
    end

endmodule

//--- src/rv_id_ex_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_id_ex_core (
    input  logic             clk,
    input  logic             rstN,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    output rv_pkg::ex_mem_t  ex_mem
);

    rv_pkg::ctrl_t    ctrl;
    logic [`XLEN-1:0] imm;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    logic [`XLEN-1:0] read1;
    logic [`XLEN-1:0] read2;
    logic             wb_en;
    rv_pkg::id_ex_t   id_bundle;
    rv_pkg::id_ex_t   id_ex;

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    // writeback of ALU results only, loads have no data here yet
    assign wb_en = ex_mem.reg_write && !ex_mem.mem_to_reg;

    reg_file u_reg_file (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .read1  (read1),
        .read2  (read2),
        .we     (wb_en),
        .wd_idx (ex_mem.rd),
        .wd     (ex_mem.result)
    );

    assign id_bundle = '{
        pc:    pc,
        ctrl:  ctrl,
        read1: read1,
        read2: read2,
        imm:   imm,
        rd:    rd,
        rs1:   rs1,
        rs2:   rs2
    };

    id_ex_reg u_id_ex_reg (
        .clk    (clk),
        .rstN   (rstN),
        .id_in  (id_bundle),
        .id_out (id_ex)
    );

    exec_stage u_exec (
        .clk    (clk),
        .rstN   (rstN),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

endmodule

//--- verif/rv_id_ex_core_sva.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_id_ex_core_sva (
    input logic             clk,
    input logic             rstN,
    input rv_pkg::id_ex_t   id_ex,
    input rv_pkg::ex_mem_t  ex_mem,
    input logic [`XLEN-1:0] src1_val,
    input logic [`XLEN-1:0] src2_val
);

    // first result after reset is the bubble
    a_no_write_after_reset: assert property (
        @(posedge clk) $rose(rstN) |=> !ex_mem.reg_write
    ) else $error("register write enabled in the cycle after reset release");

    a_result_known: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown({ex_mem.result, ex_mem.store_data})
    ) else $error("ex_mem result or store data unknown");

    // x0 operands read zero, so no write to x0 was kept or forwarded
    a_x0_src1_zero: assert property (
        @(posedge clk) disable iff (!rstN) (id_ex.rs1 == '0) |-> (src1_val == '0)
    ) else $error("rs1 of x0 returned a nonzero value");

    a_x0_src2_zero: assert property (
        @(posedge clk) disable iff (!rstN) (id_ex.rs2 == '0) |-> (src2_val == '0)
    ) else $error("rs2 of x0 returned a nonzero value");

endmodule

bind exec_stage rv_id_ex_core_sva u_sva (
    .clk      (clk),
    .rstN     (rstN),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .src1_val (src1_val),
    .src2_val (src2_val)
);

//--- verif/tb_rv_id_ex_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_id_ex_core;

    localparam logic [`XLEN-1:0] NOP = `NOP_INSTR;
    // tests take about 90 cycles and the limit leaves a wide margin
    localparam int MAX_CYCLES = 400;

    logic             clk;
    logic             rstN;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    rv_pkg::ex_mem_t  ex_mem;

    // architectural register model and results still in flight
    logic [`XLEN-1:0] regs_m [0:`NUM_REGS-1];
    rv_pkg::ex_mem_t  exp_q [$];
    logic [`XLEN-1:0] cur_pc;
    int               n_checks = 0;
    int               n_errors = 0;
    int               cycles = 0;

    rv_id_ex_core dut (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (instr),
        .pc     (pc),
        .ex_mem (ex_mem)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] itype_instr(input logic [6:0] opc,
                                                input rv_pkg::reg_idx_t rd,
                                                input logic [2:0] f3,
                                                input rv_pkg::reg_idx_t rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // funct7 and rs2 sit where the I-type immediate would
    function automatic logic [31:0] rtype_instr(input rv_pkg::reg_idx_t rd,
                                                input logic [2:0] f3,
                                                input rv_pkg::reg_idx_t rs1,
                                                input rv_pkg::reg_idx_t rs2,
                                                input logic alt);
        return itype_instr(rv_pkg::OP, rd, f3, rs1, {1'b0, alt, 5'b0, rs2});
    endfunction

    function automatic logic [31:0] stype_instr(input logic [2:0] f3,
                                                input rv_pkg::reg_idx_t rs1,
                                                input rv_pkg::reg_idx_t rs2,
                                                input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::STORE};
    endfunction

    function automatic logic [31:0] utype_instr(input logic [6:0] opc,
                                                input rv_pkg::reg_idx_t rd,
                                                input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // RV32I integer functions by funct3 where alt picks sub and sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = {31'b0, $signed(a) < $signed(b)};
            3'd3:    r = {31'b0, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_ex_mem(input string what, input rv_pkg::ex_mem_t got,
                                input rv_pkg::ex_mem_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED ex_mem (%s): got %h, expected %h, result %h vs %h",
                     what, got, exp, got.result, exp.result);
        end
    endtask

    // models and drives one instruction and checks the one issued two slots earlier
    task automatic issue(input logic [31:0] ins);
        rv_pkg::ex_mem_t e;
        logic [31:0]     a;
        logic [31:0]     imm_i;
        a            = regs_m[ins[19:15]];
        imm_i        = {{20{ins[31]}}, ins[31:20]};
        e            = '0;
        e.store_data = regs_m[ins[24:20]];
        e.rd         = ins[11:7];
        e.funct3     = ins[14:12];
        case (rv_pkg::opcode_t'(ins[6:0]))
            rv_pkg::OP: begin
                e.result    = alu_ref(ins[14:12], ins[30], a, e.store_data);
                e.reg_write = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                e.result    = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
                e.reg_write = 1'b1;
            end
            rv_pkg::LUI, rv_pkg::AUIPC: begin
                e.result    = {ins[31:12], 12'b0};
                if (ins[6:0] == rv_pkg::AUIPC)
                    e.result = e.result + cur_pc;
                e.funct3    = 3'd0;
                e.reg_write = 1'b1;
            end
            rv_pkg::LOAD: begin
                e.result     = a + imm_i;
                e.mem_read   = 1'b1;
                e.mem_to_reg = 1'b1;
                e.reg_write  = 1'b1;
            end
            rv_pkg::STORE: begin
                e.result    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                e.mem_write = 1'b1;
            end
            // only supported opcodes are issued
            default: ;
        endcase
        // load data never comes back, so only ALU results land in the model
        if (e.reg_write && !e.mem_to_reg && e.rd != '0)
            regs_m[e.rd] = e.result;
        @(posedge clk);
        #1;
        if (exp_q.size() == 2)
            check_ex_mem("pipeline", ex_mem, exp_q.pop_front());
        instr = ins;
        pc    = cur_pc;
        exp_q.push_back(e);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic apply_reset();
        rstN   = 1'b0;
        instr  = NOP;
        pc     = `RESET_PC;
        cur_pc = `RESET_PC;
        repeat (10) @(posedge clk);
        #1;
        check_ex_mem("in reset", ex_mem, '0);
        rstN = 1'b1;
        @(posedge clk);
        #1;
        // first result out of reset comes from the ID/EX bubble
        check_ex_mem("after reset", ex_mem, '0);
        check_word("ex_mem.result", ex_mem.result, '0);
        check_word("ex_mem.store_data", ex_mem.store_data, '0);
    endtask

    task automatic alu_ops();
        logic [31:0] rnd;
        for (int r = 1; r <= 4; r++) begin
            rnd = $urandom;
            issue(utype_instr(rv_pkg::LUI, 5'(r), rnd[31:12]));
            issue(itype_instr(rv_pkg::OP_IMM, 5'(r), 3'd0, 5'(r), rnd[11:0]));
        end
        for (int f = 0; f < 8; f++) begin
            issue(rtype_instr(5'(10 + f), 3'(f), 5'd1, 5'd2, 1'b0));
            if (f == 0 || f == 5)
                issue(rtype_instr(5'(20 + f), 3'(f), 5'd3, 5'd4, 1'b1));
        end
        for (int f = 0; f < 8; f++) begin
            rnd = $urandom;
            // shifts carry shamt plus the srai bit
            if (f == 1 || f == 5)
                rnd[11:0] = {1'b0, rnd[11] && f == 5, 5'b0, rnd[4:0]};
            issue(itype_instr(rv_pkg::OP_IMM, 5'(10 + f), 3'(f), 5'(1 + f % 4), rnd[11:0]));
        end
        issue(itype_instr(rv_pkg::OP_IMM, 5'd26, 3'd5, 5'd4, {7'b0100000, rnd[16:12]}));
    endtask

    task automatic upper_imm_ops();
        logic [31:0] rnd;
        for (int k = 0; k < 4; k++) begin
            rnd = $urandom;
            issue(utype_instr(rv_pkg::LUI, 5'(5 + k), rnd[31:12]));
            cur_pc = {rnd[13:0], rnd[31:16], 2'b00};
            issue(utype_instr(rv_pkg::AUIPC, 5'(9 + k), rnd[19:0]));
        end
    endtask

    // gap of g bubbles puts the consumer at distance g+1
    task automatic dependency_chains();
        logic [31:0] rnd;
        for (int gap = 0; gap < 3; gap++) begin
            rnd = $urandom;
            issue(itype_instr(rv_pkg::OP_IMM, 5'd7, 3'd0, 5'd0, rnd[11:0]));
            repeat (gap) issue(NOP);
            issue(rtype_instr(5'd8, 3'd0, 5'd7, 5'd7, 1'b0));
            repeat (gap) issue(NOP);
            issue(rtype_instr(5'd9, 3'd0, 5'd8, 5'd7, 1'b1));
            repeat (gap) issue(NOP);
            // store data comes from the latest producer
            issue(stype_instr(3'd2, 5'd8, 5'd9, rnd[23:12]));
        end
    endtask

    task automatic load_store_ops();
        logic [31:0] rnd;
        for (int f = 0; f < 3; f++) begin
            rnd = $urandom;
            issue(stype_instr(3'(f), 5'(10 + f), 5'(11 + f), rnd[11:0]));
        end
        for (int f = 0; f < 6; f++) begin
            rnd = $urandom;
            if (f != 3)
                issue(itype_instr(rv_pkg::LOAD, 5'(12 + f), 3'(f), 5'(10 + f), rnd[11:0]));
        end
        // loaded registers still hold their old values
        issue(rtype_instr(5'd20, 3'd0, 5'd17, 5'd12, 1'b0));
        issue(rtype_instr(5'd21, 3'd4, 5'd14, 5'd13, 1'b0));
    endtask

    task automatic x0_writes();
        logic [31:0] rnd;
        rnd = $urandom;
        issue(itype_instr(rv_pkg::OP_IMM, 5'd0, 3'd0, 5'd1, rnd[11:0]));
        issue(rtype_instr(5'd22, 3'd0, 5'd0, 5'd0, 1'b0));
        issue(utype_instr(rv_pkg::LUI, 5'd0, rnd[31:12]));
        issue(NOP);
        issue(rtype_instr(5'd23, 3'd6, 5'd0, 5'd2, 1'b0));
        issue(rtype_instr(5'd0, 3'd0, 5'd1, 5'd2, 1'b0));
        issue(NOP);
        issue(NOP);
        issue(stype_instr(3'd2, 5'd0, 5'd0, 12'h010));
    endtask

    initial begin
        void'($urandom(12285));
        for (int i = 0; i < `NUM_REGS; i++)
            regs_m[i] = '0;
        apply_reset();
        alu_ops();
        upper_imm_ops();
        dependency_chains();
        load_store_ops();
        x0_writes();
        // push the last real results out of the pipeline
        repeat (2) issue(NOP);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/rv_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/id_ex_reg.sv
src/exec_stage.sv
src/rv_id_ex_core.sv
verif/rv_id_ex_core_sva.sv
verif/tb_rv_id_ex_core.sv

//--- Makefile
TOP := tb_rv_id_ex_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module rv_id_ex_core +incdir+src \
		src/rv_pkg.sv src/instr_decoder.sv src/reg_file.sv src/id_ex_reg.sv \
		src/exec_stage.sv src/rv_id_ex_core.sv

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
